// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module rv_core_tb -f sim.f -o Vrv_core_tb

./obj_dir/Vrv_core_tb | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

// File: rv_alu.sv
`default_nettype none

`include "rv_config.svh"

module rv_alu (
  input  wire logic [`RV_XLEN-1:0] i_a,
  input  wire logic [`RV_XLEN-1:0] i_b,
  input  wire rv_pkg::rv_alu_op_e  i_op,
  input  wire rv_pkg::rv_branch_e  i_branch,
  input  wire logic [`RV_XLEN-1:0] i_cmp_b,
  output logic [`RV_XLEN-1:0]      o_result,
  output logic                     o_taken
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic cmp_eq;
  logic cmp_lt;
  logic cmp_ltu;

  assign shamt = i_b[SHAMT_W-1:0];

  always_comb begin
    case (i_op)
      rv_pkg::ALU_SUB:  o_result = i_a - i_b;
      rv_pkg::ALU_SLL:  o_result = i_a << shamt;
      rv_pkg::ALU_SLT:  o_result = {{(`RV_XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      rv_pkg::ALU_SLTU: o_result = {{(`RV_XLEN-1){1'b0}}, i_a < i_b};
      rv_pkg::ALU_XOR:  o_result = i_a ^ i_b;
      rv_pkg::ALU_SRL:  o_result = i_a >> shamt;
      rv_pkg::ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
      rv_pkg::ALU_OR:   o_result = i_a | i_b;
      rv_pkg::ALU_AND:  o_result = i_a & i_b;
      default:          o_result = i_a + i_b;
    endcase
  end

  // branch compare always uses rs2, the b operand may hold an immediate
  assign cmp_eq  = (i_a == i_cmp_b);
  assign cmp_lt  = ($signed(i_a) < $signed(i_cmp_b));
  assign cmp_ltu = (i_a < i_cmp_b);

  always_comb begin
    case (i_branch)
      rv_pkg::BR_BEQ:  o_taken = cmp_eq;
      rv_pkg::BR_BNE:  o_taken = !cmp_eq;
      rv_pkg::BR_BLT:  o_taken = cmp_lt;
      rv_pkg::BR_BGE:  o_taken = !cmp_lt;
      rv_pkg::BR_BLTU: o_taken = cmp_ltu;
      rv_pkg::BR_BGEU: o_taken = !cmp_ltu;
      default:         o_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width, one word
`define RV_XLEN 32

// register index width and count
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// byte strobes per data word
`define RV_STRB_W 4

`endif

// File: rv_core.sv
`default_nettype none

`include "rv_config.svh"

module rv_core (
  input  wire                      clk,
  input  wire                      rst,
  input  wire logic [`RV_XLEN-1:0] i_insn,
  input  wire logic [`RV_XLEN-1:0] i_dmem_rdata,
  output logic [`RV_XLEN-1:0]      o_pc,
  output rv_pkg::rv_dmem_req_t     o_dmem,
  output logic                     o_halt
);

  rv_pkg::rv_dec_t dec;
  rv_pkg::rv_dmem_req_t lsu_req;

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_next;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_plus_imm;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] load_data;
  logic [`RV_XLEN-1:0] wb_data;
  logic                taken;
  logic                rd_we;

  rv_decoder decoder_i (
    .i_insn (i_insn),
    .o_dec  (dec)
  );

  rv_regfile regfile_i (
    .clk        (clk),
    .rst        (rst),
    .i_rs1_addr (dec.rs1),
    .i_rs2_addr (dec.rs2),
    .i_rd_addr  (dec.rd),
    .i_rd_we    (rd_we),
    .i_rd_data  (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu alu_i (
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .i_op     (dec.alu_op),
    .i_branch (dec.branch),
    .i_cmp_b  (rs2_data),
    .o_result (alu_result),
    .o_taken  (taken)
  );

  // loads and stores decode to add with the immediate, so this is rs1+imm
  rv_lsu lsu_i (
    .i_dec        (dec),
    .i_addr       (alu_result),
    .i_store_data (rs2_data),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem       (lsu_req),
    .o_load_data  (load_data)
  );

  // ecall or an unknown word stops the core until the next reset
  assign o_halt = !rst && (dec.ecall || dec.illegal);

  assign pc_plus4    = pc + `RV_XLEN'(4);
  assign pc_plus_imm = pc + dec.imm;

  always_comb begin
    if (dec.load) begin
      wb_data = load_data;
    end else if (dec.jal || dec.jalr) begin
      wb_data = pc_plus4;
    end else if (dec.lui) begin
      wb_data = dec.imm;
    end else if (dec.auipc) begin
      wb_data = pc_plus_imm;
    end else begin
      wb_data = alu_result;
    end
  end

  assign rd_we = dec.reg_we && !o_halt;

  always_comb begin
    o_dmem = lsu_req;
    if (rst || o_halt) begin
      o_dmem.strb = '0;
    end
  end

  // halted pc holds on the ecall or illegal word
  always_comb begin
    if (o_halt) begin
      pc_next = pc;
    end else if (dec.jalr) begin
      pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else if (dec.jal || taken) begin
      pc_next = pc_plus_imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign o_pc = pc;

endmodule

`default_nettype wire

// File: rv_core_props.sv
`default_nettype none

`include "rv_config.svh"

module rv_core_props (
  input wire logic                 i_clk,
  input wire logic                 i_rst,
  input wire logic [`RV_XLEN-1:0]  i_pc,
  input wire rv_pkg::rv_dmem_req_t i_dmem,
  input wire logic                 i_halt
);
  timeunit 1ns;
  timeprecision 100ps;

  // the lane sits in the strobes, never in the address
  store_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    (|i_dmem.strb) |-> (i_dmem.addr[1:0] == 2'b00))
    else $error("store address %h is not word aligned", i_dmem.addr);

  strb_legal: assert property (@(posedge i_clk)
    (i_dmem.strb inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                         4'b0011, 4'b1100, 4'b1111}))
    else $error("byte strobes %b form no byte, half or word", i_dmem.strb);

  // a halted core sits on the ecall or illegal word
  pc_held: assert property (@(posedge i_clk) disable iff (i_rst)
    i_halt |=> $stable(i_pc))
    else $error("pc moved while the core was halted");

  no_store_in_reset: assert property (@(posedge i_clk)
    i_rst |-> (i_dmem.strb == '0))
    else $error("store strobes set during reset");

endmodule

bind rv_core rv_core_props props_i (
  .i_clk  (clk),
  .i_rst  (rst),
  .i_pc   (o_pc),
  .i_dmem (o_dmem),
  .i_halt (o_halt)
);

`default_nettype wire

// File: rv_core_tb.sv
`default_nettype none

`include "rv_config.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS   = 128;
  localparam int MEM_AW      = 7;
  localparam int PROG_WORDS  = 16;
  localparam int TABLE_SIZE  = 52;
  localparam int CYCLE_LIMIT = TABLE_SIZE * (PROG_WORDS + 8) * 2;
  localparam int DATA_WORD   = 64;
  localparam logic [31:0] DATA_ADDR = 32'h0000_0100;
  localparam logic [31:0] ECALL     = 32'h0000_0073;
  localparam logic [31:0] NOP       = 32'h0000_0013;
  localparam logic [31:0] ALU_A     = 32'h8765_4321;
  localparam logic [31:0] ALU_B     = 32'h0000_0024;
  localparam logic [31:0] FILL      = 32'hDEAD_BEEF;

  typedef struct packed {
    logic [31:0] halt_pc;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] preload;
  } test_exp_t;

  logic                 clk;
  logic                 rst;
  logic [`RV_XLEN-1:0]  insn;
  logic [`RV_XLEN-1:0]  dmem_rdata;
  logic [`RV_XLEN-1:0]  pc;
  rv_pkg::rv_dmem_req_t dmem;
  logic                 halt;
  logic [31:0]          merged;

  logic [31:0] mem [MEM_WORDS] = '{default: '0};
  logic [31:0] prog [TABLE_SIZE][PROG_WORDS];
  test_exp_t   exp_tab [TABLE_SIZE];
  string       test_name [TABLE_SIZE];
  int          n_tests;
  int          pos;
  int          cur_test;
  int          pass_count;
  int          fail_count;
  int          cycles = 0;
  logic        load_req;
  logic        store_seen = 1'b0;
  logic [31:0] last_addr = '0;
  logic [3:0]  last_strb = '0;
  logic [31:0] last_word = '0;

  tb_clock #(.PERIOD_NS(4.0)) clock_i (.o_clk(clk));

  rv_core dut_i (
    .clk          (clk),
    .rst          (rst),
    .i_insn       (insn),
    .i_dmem_rdata (dmem_rdata),
    .o_pc         (pc),
    .o_dmem       (dmem),
    .o_halt       (halt)
  );

  // one array serves fetch and data, both answer in the same cycle
  assign insn       = mem[pc[MEM_AW+1:2]];
  assign dmem_rdata = mem[dmem.addr[MEM_AW+1:2]];

  always_comb begin
    merged = dmem_rdata;
    for (int b = 0; b < 4; b++) begin
      if (dmem.strb[b]) begin
        merged[8*b +: 8] = dmem.wdata[8*b +: 8];
      end
    end
  end

  always @(posedge clk) begin
    if (load_req) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        if (i < PROG_WORDS) begin
          mem[i] <= prog[cur_test][i];
        end else if (i == DATA_WORD) begin
          mem[i] <= exp_tab[cur_test].preload;
        end else begin
          mem[i] <= '0;
        end
      end
      store_seen <= 1'b0;
    end else if (|dmem.strb) begin
      mem[dmem.addr[MEM_AW+1:2]] <= merged;
      store_seen <= 1'b1;
      last_addr  <= dmem.addr;
      last_strb  <= dmem.strb;
      last_word  <= merged;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("cycle limit of %0d reached before the tests finished", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] asm_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] asm_imm(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] asm_load(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] asm_store(input logic [2:0] f3, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] asm_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] asm_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic begin_test(input string name);
    pos = 0;
    if (n_tests < TABLE_SIZE) begin
      test_name[n_tests] = name;
      for (int i = 0; i < PROG_WORDS; i++) begin
        prog[n_tests][i] = '0;
      end
    end
  endtask

  task automatic emit(input logic [31:0] word);
    if (n_tests < TABLE_SIZE && pos < PROG_WORDS) begin
      prog[n_tests][pos] = word;
    end
    pos++;
  endtask

  task automatic end_test(input logic [31:0] halt_pc, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] preload);
    if (n_tests < TABLE_SIZE) begin
      exp_tab[n_tests] = {halt_pc, addr, data, preload};
    end
    n_tests++;
  endtask

  // lui then addi, the upper part absorbs the sign of the low 12 bits
  task automatic emit_li(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h0000_0800;
    emit(asm_lui(rd, upper[31:12]));
    emit(asm_imm(3'b000, rd, rd, value[11:0]));
  endtask

  // x1 = ALU_A, x2 = ALU_B, the op writes x3
  task automatic add_alu_test(input string name, input logic [31:0] op,
                              input logic [31:0] expected);
    begin_test(name);
    emit_li(5'd1, ALU_A);
    emit_li(5'd2, ALU_B);
    emit(op);
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_001C, DATA_ADDR, expected, FILL);
  endtask

  // x1 = -1 and x2 = 1, so signed and unsigned order disagree
  task automatic add_branch_test(input string name, input logic [31:0] br, input logic taken);
    begin_test(name);
    emit(asm_imm(3'b000, 5'd1, 5'd0, 12'hFFF));
    emit(asm_imm(3'b000, 5'd2, 5'd0, 12'h001));
    emit(asm_imm(3'b000, 5'd3, 5'd0, 12'h011));
    emit(br);
    emit(asm_imm(3'b000, 5'd3, 5'd0, 12'h022));
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_001C, DATA_ADDR, taken ? 32'h0000_0011 : 32'h0000_0022, FILL);
  endtask

  task automatic add_lane_store_test(input string name, input logic [2:0] f3,
                                     input logic [11:0] offset, input logic [31:0] expected);
    begin_test(name);
    emit_li(5'd1, 32'h0000_CDAB);
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(f3, 5'd1, 5'd5, offset));
    emit(ECALL);
    end_test(32'h0000_0010, DATA_ADDR, expected, 32'h1122_3344);
  endtask

  // the loaded value is stored one word above the preloaded word
  task automatic add_load_test(input string name, input logic [2:0] f3,
                               input logic [11:0] offset, input logic [31:0] expected);
    begin_test(name);
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_load(f3, 5'd3, 5'd5, offset));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h004));
    emit(ECALL);
    end_test(32'h0000_000C, DATA_ADDR + 32'h4, expected, 32'h8765_F0A5);
  endtask

  task automatic build_table();
    add_alu_test("add", asm_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 32'h8765_4345);
    add_alu_test("sub", asm_op(7'h20, 3'b000, 5'd3, 5'd1, 5'd2), 32'h8765_42FD);
    add_alu_test("sll", asm_op(7'h00, 3'b001, 5'd3, 5'd1, 5'd2), 32'h7654_3210);
    add_alu_test("slt", asm_op(7'h00, 3'b010, 5'd3, 5'd1, 5'd2), 32'h0000_0001);
    add_alu_test("sltu", asm_op(7'h00, 3'b011, 5'd3, 5'd1, 5'd2), 32'h0000_0000);
    add_alu_test("xor", asm_op(7'h00, 3'b100, 5'd3, 5'd1, 5'd2), 32'h8765_4305);
    add_alu_test("srl", asm_op(7'h00, 3'b101, 5'd3, 5'd1, 5'd2), 32'h0876_5432);
    add_alu_test("sra", asm_op(7'h20, 3'b101, 5'd3, 5'd1, 5'd2), 32'hF876_5432);
    add_alu_test("or", asm_op(7'h00, 3'b110, 5'd3, 5'd1, 5'd2), 32'h8765_4325);
    add_alu_test("and", asm_op(7'h00, 3'b111, 5'd3, 5'd1, 5'd2), 32'h0000_0020);
    add_alu_test("addi", asm_imm(3'b000, 5'd3, 5'd1, 12'hFFF), 32'h8765_4320);
    add_alu_test("slti", asm_imm(3'b010, 5'd3, 5'd1, 12'h005), 32'h0000_0001);
    add_alu_test("sltiu", asm_imm(3'b011, 5'd3, 5'd1, 12'hFFF), 32'h0000_0001);
    add_alu_test("xori", asm_imm(3'b100, 5'd3, 5'd1, 12'h0FF), 32'h8765_43DE);
    add_alu_test("ori", asm_imm(3'b110, 5'd3, 5'd1, 12'h700), 32'h8765_4721);
    add_alu_test("andi", asm_imm(3'b111, 5'd3, 5'd1, 12'h0F0), 32'h0000_0020);
    add_alu_test("slli", asm_imm(3'b001, 5'd3, 5'd1, 12'h008), 32'h6543_2100);
    add_alu_test("srli", asm_imm(3'b101, 5'd3, 5'd1, 12'h00C), 32'h0008_7654);
    add_alu_test("srai", asm_imm(3'b101, 5'd3, 5'd1, 12'h40C), 32'hFFF8_7654);

    begin_test("lui");
    emit(asm_lui(5'd3, 20'hABCDE));
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_000C, DATA_ADDR, 32'hABCD_E000, FILL);

    // auipc sits at pc 8
    begin_test("auipc");
    emit(NOP);
    emit(NOP);
    emit({20'h00001, 5'd3, 7'b0010111});
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_0014, DATA_ADDR, 32'h0000_1008, FILL);

    add_branch_test("beq taken", asm_branch(3'b000, 5'd1, 5'd1, 13'h008), 1'b1);
    add_branch_test("beq not taken", asm_branch(3'b000, 5'd1, 5'd2, 13'h008), 1'b0);
    add_branch_test("bne taken", asm_branch(3'b001, 5'd1, 5'd2, 13'h008), 1'b1);
    add_branch_test("bne not taken", asm_branch(3'b001, 5'd1, 5'd1, 13'h008), 1'b0);
    add_branch_test("blt taken", asm_branch(3'b100, 5'd1, 5'd2, 13'h008), 1'b1);
    add_branch_test("blt not taken", asm_branch(3'b100, 5'd2, 5'd1, 13'h008), 1'b0);
    add_branch_test("bge taken", asm_branch(3'b101, 5'd2, 5'd1, 13'h008), 1'b1);
    add_branch_test("bge not taken", asm_branch(3'b101, 5'd1, 5'd2, 13'h008), 1'b0);
    add_branch_test("bltu taken", asm_branch(3'b110, 5'd2, 5'd1, 13'h008), 1'b1);
    add_branch_test("bltu not taken", asm_branch(3'b110, 5'd1, 5'd2, 13'h008), 1'b0);
    add_branch_test("bgeu taken", asm_branch(3'b111, 5'd1, 5'd2, 13'h008), 1'b1);
    add_branch_test("bgeu not taken", asm_branch(3'b111, 5'd2, 5'd1, 13'h008), 1'b0);

    // jal at pc 4 skips one word, link is 8
    begin_test("jal");
    emit(NOP);
    emit({1'b0, 10'h004, 1'b0, 8'h00, 5'd3, 7'b1101111});
    emit(asm_imm(3'b000, 5'd3, 5'd0, 12'h055));
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_0014, DATA_ADDR, 32'h0000_0008, FILL);

    // 15 + 2 = 17 is odd, the jump lands on 16
    begin_test("jalr odd target");
    emit(NOP);
    emit(asm_imm(3'b000, 5'd1, 5'd0, 12'h00F));
    emit({12'h002, 5'd1, 3'b000, 5'd3, 7'b1100111});
    emit(asm_imm(3'b000, 5'd3, 5'd0, 12'h055));
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_0018, DATA_ADDR, 32'h0000_000C, FILL);

    add_lane_store_test("sb offset 0", 3'b000, 12'h000, 32'h1122_33AB);
    add_lane_store_test("sb offset 1", 3'b000, 12'h001, 32'h1122_AB44);
    add_lane_store_test("sb offset 2", 3'b000, 12'h002, 32'h11AB_3344);
    add_lane_store_test("sb offset 3", 3'b000, 12'h003, 32'hAB22_3344);
    add_lane_store_test("sh offset 0", 3'b001, 12'h000, 32'h1122_CDAB);
    add_lane_store_test("sh offset 2", 3'b001, 12'h002, 32'hCDAB_3344);

    add_load_test("lb offset 0", 3'b000, 12'h000, 32'hFFFF_FFA5);
    add_load_test("lbu offset 0", 3'b100, 12'h000, 32'h0000_00A5);
    add_load_test("lb offset 3", 3'b000, 12'h003, 32'hFFFF_FF87);
    add_load_test("lbu offset 1", 3'b100, 12'h001, 32'h0000_00F0);
    add_load_test("lh offset 0", 3'b001, 12'h000, 32'hFFFF_F0A5);
    add_load_test("lhu offset 0", 3'b101, 12'h000, 32'h0000_F0A5);
    add_load_test("lh offset 2", 3'b001, 12'h002, 32'hFFFF_8765);
    add_load_test("lhu offset 2", 3'b101, 12'h002, 32'h0000_8765);
    add_load_test("lw", 3'b010, 12'h000, 32'h8765_F0A5);

    begin_test("x0 write ignored");
    emit(asm_imm(3'b000, 5'd0, 5'd0, 12'h07F));
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd0, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_000C, DATA_ADDR, 32'h0000_0000, FILL);

    // mul at pc 12 must stop the core before the second store
    begin_test("illegal mul halts");
    emit(asm_imm(3'b000, 5'd1, 5'd0, 12'h066));
    emit(asm_imm(3'b000, 5'd5, 5'd0, 12'h100));
    emit(asm_store(3'b010, 5'd1, 5'd5, 12'h000));
    emit(asm_op(7'h01, 3'b000, 5'd3, 5'd1, 5'd1));
    emit(asm_store(3'b010, 5'd3, 5'd5, 12'h000));
    emit(ECALL);
    end_test(32'h0000_000C, DATA_ADDR, 32'h0000_0066, FILL);
  endtask

  task automatic run_test(input int t);
    test_exp_t   e;
    int          errs;
    logic [31:0] word;
    e    = exp_tab[t];
    errs = 0;
    @(posedge clk);
    #1;
    rst      = 1'b1;
    cur_test = t;
    load_req = 1'b1;
    @(posedge clk);
    #1;
    load_req = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!halt);
    word = mem[e.addr[MEM_AW+1:2]];
    if (pc !== e.halt_pc) begin
      $display("[FAIL] %s: o_pc expected %h got %h", test_name[t], e.halt_pc, pc);
      errs++;
    end
    if (word !== e.data) begin
      $display("[FAIL] %s: mem[%h] expected %h got %h", test_name[t], e.addr, e.data, word);
      errs++;
    end
    if (!store_seen) begin
      $display("%s: no store reached data memory before the halt", test_name[t]);
      errs++;
    end else if (last_addr !== e.addr || last_word !== e.data) begin
      $display("[FAIL] %s: last store expected %h at %h got %h at %h (strb %h)",
               test_name[t], e.data, e.addr, last_word, last_addr, last_strb);
      errs++;
    end
    if (errs == 0) begin
      $display("[PASS] %s", test_name[t]);
      pass_count++;
    end else begin
      $display("test %s finished with %0d error(s)", test_name[t], errs);
      fail_count++;
    end
  endtask

  initial begin
    rst        = 1'b1;
    load_req   = 1'b0;
    cur_test   = 0;
    n_tests    = 0;
    pass_count = 0;
    fail_count = 0;
    build_table();
    if (n_tests != TABLE_SIZE) begin
      $display("table holds %0d tests where %0d were expected", n_tests, TABLE_SIZE);
      fail_count++;
    end
    for (int t = 0; t < n_tests && t < TABLE_SIZE; t++) begin
      run_test(t);
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_decoder.sv
`default_nettype none

`include "rv_config.svh"

module rv_decoder (
  input  wire logic [`RV_XLEN-1:0] i_insn,
  output rv_pkg::rv_dec_t          o_dec
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  rv_pkg::rv_mem_size_e size_f3;

  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  // immediates of each format, sign bit is always insn[31]
  assign imm_i = {{(`RV_XLEN-12){i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{(`RV_XLEN-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{(`RV_XLEN-13){i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                  i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                  i_insn[30:21], 1'b0};

  // access width shared by loads and stores
  assign size_f3 = (funct3[1:0] == 2'b00) ? rv_pkg::MEM_BYTE :
                   (funct3[1:0] == 2'b01) ? rv_pkg::MEM_HALF : rv_pkg::MEM_WORD;

  // alt picks sub over add and sra over srl
  function automatic rv_pkg::rv_alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    rv_pkg::rv_alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    o_dec          = '0;
    o_dec.rs1      = i_insn[19:15];
    o_dec.rs2      = i_insn[24:20];
    o_dec.rd       = i_insn[11:7];
    o_dec.imm      = imm_i;
    o_dec.alu_op   = rv_pkg::ALU_ADD;
    o_dec.branch   = rv_pkg::BR_NONE;
    o_dec.mem_size = size_f3;
    case (i_insn[6:0])
      rv_pkg::OPC_OP: begin
        o_dec.reg_we = 1'b1;
        o_dec.alu_op = alu_op_of(funct3, funct7[5]);
        // funct7 0000001 (M extension) lands here as well
        if (funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          o_dec.illegal = 1'b1;
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        o_dec.reg_we  = 1'b1;
        o_dec.use_imm = 1'b1;
        o_dec.alu_op  = alu_op_of(funct3, funct3 == 3'b101 && funct7[5]);
        if ((funct3 == 3'b001 && funct7 != 7'b0000000) ||
            (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000)) begin
          o_dec.illegal = 1'b1;
        end
      end
      rv_pkg::OPC_LOAD: begin
        o_dec.reg_we        = 1'b1;
        o_dec.use_imm       = 1'b1;
        o_dec.load          = 1'b1;
        o_dec.load_unsigned = funct3[2];
        // no lwu, no 64-bit loads
        o_dec.illegal       = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv_pkg::OPC_STORE: begin
        o_dec.imm     = imm_s;
        o_dec.use_imm = 1'b1;
        o_dec.store   = 1'b1;
        o_dec.illegal = (funct3[2] == 1'b1) || (funct3[1:0] == 2'b11);
      end
      rv_pkg::OPC_BRANCH: begin
        o_dec.imm = imm_b;
        case (funct3)
          3'b000:  o_dec.branch = rv_pkg::BR_BEQ;
          3'b001:  o_dec.branch = rv_pkg::BR_BNE;
          3'b100:  o_dec.branch = rv_pkg::BR_BLT;
          3'b101:  o_dec.branch = rv_pkg::BR_BGE;
          3'b110:  o_dec.branch = rv_pkg::BR_BLTU;
          3'b111:  o_dec.branch = rv_pkg::BR_BGEU;
          default: o_dec.illegal = 1'b1;
        endcase
      end
      rv_pkg::OPC_JAL: begin
        o_dec.imm    = imm_j;
        o_dec.reg_we = 1'b1;
        o_dec.jal    = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        o_dec.reg_we  = 1'b1;
        o_dec.use_imm = 1'b1;
        o_dec.jalr    = 1'b1;
        o_dec.illegal = (funct3 != 3'b000);
      end
      rv_pkg::OPC_LUI: begin
        o_dec.imm    = imm_u;
        o_dec.reg_we = 1'b1;
        o_dec.lui    = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        o_dec.imm    = imm_u;
        o_dec.reg_we = 1'b1;
        o_dec.auipc  = 1'b1;
      end
      rv_pkg::OPC_SYSTEM: begin
        // only ecall, ebreak and csr access are not supported
        if (i_insn[31:7] == '0) begin
          o_dec.ecall = 1'b1;
        end else begin
          o_dec.illegal = 1'b1;
        end
      end
      default: o_dec.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_lsu.sv
`default_nettype none

`include "rv_config.svh"

module rv_lsu (
  input  wire rv_pkg::rv_dec_t     i_dec,
  input  wire logic [`RV_XLEN-1:0] i_addr,
  input  wire logic [`RV_XLEN-1:0] i_store_data,
  input  wire logic [`RV_XLEN-1:0] i_dmem_rdata,
  output rv_pkg::rv_dmem_req_t     o_dmem,
  output logic [`RV_XLEN-1:0]      o_load_data
);

  logic [1:0] lane;
  logic [`RV_STRB_W-1:0] strb_base;
  logic [`RV_XLEN-1:0] rdata_lane;
  logic sign_bit;

  // lane offset in bytes, halves are forced to an even lane
  always_comb begin
    case (i_dec.mem_size)
      rv_pkg::MEM_BYTE: begin
        lane      = i_addr[1:0];
        strb_base = {{(`RV_STRB_W-1){1'b0}}, 1'b1};
      end
      rv_pkg::MEM_HALF: begin
        lane      = {i_addr[1], 1'b0};
        strb_base = {{(`RV_STRB_W-2){1'b0}}, 2'b11};
      end
      default: begin
        lane      = 2'b00;
        strb_base = '1;
      end
    endcase
  end

  assign o_dmem.addr  = {i_addr[`RV_XLEN-1:2], 2'b00};
  assign o_dmem.wdata = i_store_data << {lane, 3'b000};
  assign o_dmem.strb  = i_dec.store ? (strb_base << lane) : '0;

  // move the addressed byte or half down to bit 0 before extending
  assign rdata_lane = i_dmem_rdata >> {lane, 3'b000};

  always_comb begin
    case (i_dec.mem_size)
      rv_pkg::MEM_BYTE: begin
        sign_bit    = rdata_lane[7] && !i_dec.load_unsigned;
        o_load_data = {{(`RV_XLEN-8){sign_bit}}, rdata_lane[7:0]};
      end
      rv_pkg::MEM_HALF: begin
        sign_bit    = rdata_lane[15] && !i_dec.load_unsigned;
        o_load_data = {{(`RV_XLEN-16){sign_bit}}, rdata_lane[15:0]};
      end
      default: begin
        sign_bit    = 1'b0;
        o_load_data = rdata_lane;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } rv_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } rv_alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } rv_branch_e;

  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } rv_mem_size_e;

  // one decoded instruction
  typedef struct packed {
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       imm;
    rv_alu_op_e                alu_op;
    rv_branch_e                branch;
    rv_mem_size_e              mem_size;
    logic                      use_imm;
    logic                      reg_we;
    logic                      load;
    logic                      store;
    logic                      load_unsigned;
    logic                      jal;
    logic                      jalr;
    logic                      lui;
    logic                      auipc;
    logic                      ecall;
    logic                      illegal;
  } rv_dec_t;

  // request to data memory, address is word aligned
  typedef struct packed {
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_STRB_W-1:0] strb;
  } rv_dmem_req_t;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

`include "rv_config.svh"

module rv_regfile (
  input  wire                             clk,
  input  wire                             rst,
  input  wire logic [`RV_REG_ADDR_W-1:0]  i_rs1_addr,
  input  wire logic [`RV_REG_ADDR_W-1:0]  i_rs2_addr,
  input  wire logic [`RV_REG_ADDR_W-1:0]  i_rd_addr,
  input  wire                             i_rd_we,
  input  wire logic [`RV_XLEN-1:0]        i_rd_data,
  output logic [`RV_XLEN-1:0]             o_rs1_data,
  output logic [`RV_XLEN-1:0]             o_rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_we && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // x0 is cleared by reset and never written, so it reads zero
  assign o_rs1_data = regs[i_rs1_addr];
  assign o_rs2_data = regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_clock.sv
rv_core_props.sv
rv_core_tb.sv

// File: tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire
